// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;
    localparam int NWAY = 2;
    localparam int NSET = 64;

    localparam int OFFSET_W = $clog2(LINE_W / 8);
    localparam int INDEX_W = $clog2(NSET);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int LINE_BYTES = LINE_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // same codes as the memory bus size field
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010,
        SIZE_LINE = 3'b100
    } mem_size_e;

    typedef enum logic [1:0] {
        MISS_CACHED,
        MISS_UNC_RD,
        MISS_UNC_WR
    } miss_kind_e;

    typedef enum logic [3:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        UNC_RD_REQ,
        UNC_RD_WAIT,
        UNC_WR_REQ,
        UNC_WR_WAIT
    } ctrl_state_e;

    // strobed bytes of wdata replace the addressed word of the line
    function automatic line_t merge_store(
        input line_t                               line,
        input logic [$clog2(WORDS_PER_LINE)-1:0]   word_off,
        input logic [3:0]                          wstrb,
        input word_t                               wdata
    );
        line_t merged;
        merged = line;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (wstrb[b]) begin
                merged[word_off * WORD_W + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// File: hdl/way_ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface way_ram_if;
    import dcache_pkg::*;

    index_t                  raddr;
    logic                    ren;
    logic                    tag_we;
    logic [LINE_BYTES-1:0]   data_we;
    index_t                  waddr;
    tag_entry_t              wtag;
    line_t                   wline;
    tag_entry_t              rtag;
    line_t                   rline;

    modport lookup (
        output raddr, ren, tag_we, data_we, waddr, wtag, wline,
        input  rtag, rline
    );

    modport way_ram (
        input  raddr, ren, tag_we, data_we, waddr, wtag, wline,
        output rtag, rline
    );
endinterface

// hand-off between the lookup pipeline and the miss controller
interface miss_if;
    import dcache_pkg::*;

    logic                          miss_start;
    miss_kind_e                    miss_kind;
    addr_t                         addr;
    mem_size_e                     size;
    logic [3:0]                    wstrb;
    word_t                         wdata;
    tag_entry_t [NWAY-1:0]         way_ent;
    line_t [NWAY-1:0]              way_line;

    logic                          fill_valid;
    logic [$clog2(NWAY)-1:0]       fill_way;
    line_t                         fill_line;
    logic                          done;
    word_t                         rdata;

    modport lookup (
        output miss_start, miss_kind, addr, size, wstrb, wdata, way_ent, way_line,
        input  fill_valid, fill_way, fill_line, done, rdata
    );

    modport miss_ctrl (
        input  miss_start, miss_kind, addr, size, wstrb, wdata, way_ent, way_line,
        output fill_valid, fill_way, fill_line, done, rdata
    );
endinterface

`default_nettype wire

// File: hdl/way_ram.sv
`timescale 1ns/1ps
`default_nettype none

module way_ram (
    input logic         clk,
    input logic         rst,
    way_ram_if.way_ram  ram
);
    import dcache_pkg::*;

    tag_entry_t tag_mem [NSET];
    line_t      data_mem [NSET];

    // valid and dirty bits start cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NSET; i++) begin
                tag_mem[i] <= '0;
            end
        end else if (ram.tag_we) begin
            tag_mem[ram.waddr] <= ram.wtag;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (ram.data_we[b]) begin
                data_mem[ram.waddr][b * 8 +: 8] <= ram.wline[b * 8 +: 8];
            end
        end
    end

    // outputs hold while ren is low, so step 2 keeps its view of the set
    always_ff @(posedge clk) begin
        if (rst) begin
            ram.rtag <= '0;
        end else if (ram.ren) begin
            ram.rtag <= tag_mem[ram.raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (ram.ren) begin
            ram.rline <= data_mem[ram.raddr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  dcache_pkg::addr_t      req_addr_i,
    input  dcache_pkg::mem_size_e  req_size_i,
    input  logic [3:0]             req_wstrb_i,
    input  dcache_pkg::word_t      req_wdata_i,
    input  logic                   req_uncached_i,
    output logic                   ready_o,
    output logic                   data_ok_o,
    output dcache_pkg::word_t      rdata_o,
    way_ram_if.lookup              ways [dcache_pkg::NWAY],
    miss_if.lookup                 miss
);
    import dcache_pkg::*;

    logic                   accept;
    logic                   s2_valid;
    logic                   s2_uncached;
    logic                   s2_store;
    logic                   miss_pend;
    addr_t                  s2_addr;
    mem_size_e              s2_size;
    logic [3:0]             s2_wstrb;
    word_t                  s2_wdata;
    tag_t                   s2_tag;
    index_t                 s2_index;
    logic [1:0]             s2_off;
    tag_entry_t [NWAY-1:0]  way_ent;
    line_t [NWAY-1:0]       way_line;
    logic [NWAY-1:0]        way_hit;
    logic                   hit;
    line_t                  hit_line;

    assign accept = req_valid_i && ready_o;

    assign s2_tag = s2_addr[ADDR_W-1 -: TAG_W];
    assign s2_index = s2_addr[OFFSET_W +: INDEX_W];
    assign s2_off = s2_addr[OFFSET_W-1:2];
    assign s2_store = |s2_wstrb;

    assign hit = s2_valid && !s2_uncached && (|way_hit);

    // only a load hit lets the next request in behind it
    assign ready_o = !s2_valid || (hit && !s2_store);
    assign data_ok_o = hit || miss.done;
    assign rdata_o = miss.done ? miss.rdata : hit_line[s2_off * WORD_W +: WORD_W];

    always_comb begin
        hit_line = way_line[0];
        for (int w = 0; w < NWAY; w++) begin
            if (way_hit[w]) begin
                hit_line = way_line[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            miss_pend <= 1'b0;
        end else begin
            if (ready_o) begin
                s2_valid <= req_valid_i;
            end else if (hit || miss.done) begin
                s2_valid <= 1'b0;
            end
            if (miss.miss_start) begin
                miss_pend <= 1'b1;
            end else if (miss.done) begin
                miss_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_addr <= req_addr_i;
            s2_size <= req_size_i;
            s2_wstrb <= req_wstrb_i;
            s2_wdata <= req_wdata_i;
            s2_uncached <= req_uncached_i;
        end
    end

    // step 2 holds until the controller reports done
    assign miss.miss_start = s2_valid && !hit && !miss_pend;
    assign miss.addr = s2_addr;
    assign miss.size = s2_size;
    assign miss.wstrb = s2_wstrb;
    assign miss.wdata = s2_wdata;
    assign miss.way_ent = way_ent;
    assign miss.way_line = way_line;

    always_comb begin
        if (!s2_uncached) begin
            miss.miss_kind = MISS_CACHED;
        end else if (s2_store) begin
            miss.miss_kind = MISS_UNC_WR;
        end else begin
            miss.miss_kind = MISS_UNC_RD;
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        assign ways[w].raddr = req_addr_i[OFFSET_W +: INDEX_W];
        assign ways[w].ren = accept;
        assign ways[w].waddr = s2_index;
        assign way_ent[w] = ways[w].rtag;
        assign way_line[w] = ways[w].rline;
        assign way_hit[w] = way_ent[w].valid && (way_ent[w].tag == s2_tag);

        always_comb begin
            ways[w].tag_we = 1'b0;
            ways[w].data_we = '0;
            ways[w].wtag = '0;
            ways[w].wline = '0;
            if (miss.fill_valid && int'(miss.fill_way) == w) begin
                ways[w].tag_we = 1'b1;
                ways[w].wtag = '{dirty: s2_store, valid: 1'b1, tag: s2_tag};
                ways[w].data_we = '1;
                ways[w].wline = miss.fill_line;
            end else if (hit && s2_store && way_hit[w]) begin
                ways[w].tag_we = 1'b1;
                ways[w].wtag = '{dirty: 1'b1, valid: 1'b1, tag: s2_tag};
                ways[w].data_we = LINE_BYTES'(s2_wstrb) << (s2_off * 4);
                ways[w].wline = merge_store(way_line[w], s2_off, s2_wstrb, s2_wdata);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    miss_if.miss_ctrl              miss,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output dcache_pkg::addr_t      mem_addr_o,
    output dcache_pkg::mem_size_e  mem_size_o,
    output dcache_pkg::line_t      mem_wdata_o,
    output logic [15:0]            mem_wstrb_o,
    input  logic                   mem_rdy_i,
    input  logic                   mem_rvalid_i,
    input  logic                   mem_bvalid_i,
    input  dcache_pkg::line_t      mem_rdata_i
);
    import dcache_pkg::*;

    ctrl_state_e  state;
    ctrl_state_e  next_state;
    logic [15:0]  lfsr;
    logic         victim;
    logic         vsel;
    tag_entry_t   victim_ent;
    index_t       index;
    logic [1:0]   word_off;
    line_t        merged_line;

    assign index = miss.addr[OFFSET_W +: INDEX_W];
    assign word_off = miss.addr[OFFSET_W-1:2];

    // victim comes straight from the lfsr in the start cycle
    assign vsel = (state == IDLE) ? lfsr[0] : victim;
    assign victim_ent = miss.way_ent[vsel];
    assign merged_line = merge_store(mem_rdata_i, word_off, miss.wstrb, miss.wdata);

    // x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            victim <= 1'b0;
        end else begin
            state <= next_state;
            if (state == IDLE && miss.miss_start) begin
                victim <= lfsr[0];
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss.miss_start) begin
                    case (miss.miss_kind)
                        MISS_UNC_RD: next_state = UNC_RD_REQ;
                        MISS_UNC_WR: next_state = UNC_WR_REQ;
                        default: begin
                            if (victim_ent.valid && victim_ent.dirty) begin
                                next_state = WB_REQ;
                            end else begin
                                next_state = FILL_REQ;
                            end
                        end
                    endcase
                end
            end
            WB_REQ: if (mem_rdy_i) next_state = WB_WAIT;
            WB_WAIT: if (mem_bvalid_i) next_state = FILL_REQ;
            FILL_REQ: if (mem_rdy_i) next_state = FILL_WAIT;
            FILL_WAIT: if (mem_rvalid_i) next_state = IDLE;
            UNC_RD_REQ: if (mem_rdy_i) next_state = UNC_RD_WAIT;
            UNC_RD_WAIT: if (mem_rvalid_i) next_state = IDLE;
            UNC_WR_REQ: if (mem_rdy_i) next_state = UNC_WR_WAIT;
            UNC_WR_WAIT: if (mem_bvalid_i) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // a request only goes out in a cycle where the memory is ready
    always_comb begin
        mem_req_o = 1'b0;
        mem_we_o = 1'b0;
        mem_addr_o = '0;
        mem_size_o = SIZE_BYTE;
        mem_wdata_o = '0;
        mem_wstrb_o = '0;
        case (state)
            WB_REQ: begin
                mem_req_o = mem_rdy_i;
                mem_we_o = 1'b1;
                mem_addr_o = {victim_ent.tag, index, {OFFSET_W{1'b0}}};
                mem_size_o = SIZE_LINE;
                mem_wdata_o = miss.way_line[vsel];
                mem_wstrb_o = '1;
            end
            FILL_REQ: begin
                mem_req_o = mem_rdy_i;
                mem_addr_o = {miss.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                mem_size_o = SIZE_LINE;
            end
            UNC_RD_REQ: begin
                mem_req_o = mem_rdy_i;
                mem_addr_o = miss.addr;
                mem_size_o = miss.size;
            end
            UNC_WR_REQ: begin
                mem_req_o = mem_rdy_i;
                mem_we_o = 1'b1;
                mem_addr_o = miss.addr;
                mem_size_o = miss.size;
                mem_wdata_o = line_t'(miss.wdata) << (word_off * WORD_W);
                mem_wstrb_o = 16'(miss.wstrb) << (word_off * 4);
            end
            default: begin
            end
        endcase
    end

    assign miss.fill_way = victim;
    assign miss.fill_line = merged_line;
    assign miss.fill_valid = (state == FILL_WAIT) && mem_rvalid_i;
    assign miss.done = ((state == FILL_WAIT || state == UNC_RD_WAIT) && mem_rvalid_i)
                       || (state == UNC_WR_WAIT && mem_bvalid_i);
    assign miss.rdata = (state == FILL_WAIT) ? merged_line[word_off * WORD_W +: WORD_W]
                                             : mem_rdata_i[word_off * WORD_W +: WORD_W];

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_valid_i,
    input  dcache_pkg::addr_t      req_addr_i,
    input  dcache_pkg::mem_size_e  req_size_i,
    input  logic [3:0]             req_wstrb_i,
    input  dcache_pkg::word_t      req_wdata_i,
    input  logic                   req_uncached_i,
    output logic                   ready_o,
    output logic                   data_ok_o,
    output dcache_pkg::word_t      rdata_o,

    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output dcache_pkg::addr_t      mem_addr_o,
    output dcache_pkg::mem_size_e  mem_size_o,
    output dcache_pkg::line_t      mem_wdata_o,
    output logic [15:0]            mem_wstrb_o,
    input  logic                   mem_rdy_i,
    input  logic                   mem_rvalid_i,
    input  logic                   mem_bvalid_i,
    input  dcache_pkg::line_t      mem_rdata_i
);
    import dcache_pkg::*;

    way_ram_if ways_if [NWAY] ();
    miss_if    miss_bus ();

    dcache_lookup u_lookup (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_addr_i     (req_addr_i),
        .req_size_i     (req_size_i),
        .req_wstrb_i    (req_wstrb_i),
        .req_wdata_i    (req_wdata_i),
        .req_uncached_i (req_uncached_i),
        .ready_o        (ready_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .ways           (ways_if),
        .miss           (miss_bus)
    );

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        way_ram u_way_ram (
            .clk (clk),
            .rst (rst),
            .ram (ways_if[w])
        );
    end

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .miss         (miss_bus),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_size_o   (mem_size_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_wstrb_o  (mem_wstrb_o),
        .mem_rdy_i    (mem_rdy_i),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_bvalid_i (mem_bvalid_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // reset drops 1 ns after the 8th rising edge
    initial begin
        rst_o = 1'b1;
        repeat (8) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end
endmodule

`default_nettype wire

// File: sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_req_i,
    input  logic               mem_we_i,
    input  dcache_pkg::addr_t  mem_addr_i,
    input  dcache_pkg::line_t  mem_wdata_i,
    input  logic [15:0]        mem_wstrb_i,
    output logic               mem_rdy_o,
    output logic               mem_rvalid_o,
    output logic               mem_bvalid_o,
    output dcache_pkg::line_t  mem_rdata_o
);
    import dcache_pkg::*;

    // only written lines are stored, the rest come from the fill pattern
    line_t lines [addr_t];

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic line_t read_line(input addr_t a);
        line_t l;
        if (lines.exists(a)) begin
            l = lines[a];
        end else begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                l[w * WORD_W +: WORD_W] = fill_word(a + addr_t'(w * 4));
            end
        end
        return l;
    endfunction

    initial begin : respond
        logic   took;
        logic   is_wr;
        logic   busy;
        int     wait_cnt;
        addr_t  line_addr;
        line_t  l;
        mem_rdy_o = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_bvalid_o = 1'b0;
        mem_rdata_o = '0;
        is_wr = 1'b0;
        busy = 1'b0;
        wait_cnt = 0;
        line_addr = '0;
        forever begin
            @(negedge clk);
            took = mem_req_i;
            if (took) begin
                is_wr = mem_we_i;
                line_addr = {mem_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                if (mem_we_i) begin
                    l = read_line(line_addr);
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (mem_wstrb_i[b]) begin
                            l[b * 8 +: 8] = mem_wdata_i[b * 8 +: 8];
                        end
                    end
                    lines[line_addr] = l;
                end
            end
            @(posedge clk);
            #1;
            mem_rvalid_o = 1'b0;
            mem_bvalid_o = 1'b0;
            if (rst) begin
                mem_rdy_o = 1'b0;
                busy = 1'b0;
            end else if (took) begin
                mem_rdy_o = 1'b0;
                busy = 1'b1;
                wait_cnt = 1 + int'($urandom % 6);
            end else if (busy) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    busy = 1'b0;
                    if (is_wr) begin
                        mem_bvalid_o = 1'b1;
                    end else begin
                        mem_rvalid_o = 1'b1;
                        mem_rdata_o = read_line(line_addr);
                    end
                end
            end else begin
                // ready about three cycles in four
                mem_rdy_o = ($urandom % 4) != 0;
            end
        end
    end
endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int NUM_REQ = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40;
    localparam addr_t UNC_BASE = 32'h0004_0000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    addr_t      req_addr;
    mem_size_e  req_size;
    logic [3:0] req_wstrb;
    word_t      req_wdata;
    logic       req_uncached;
    logic       ready;
    logic       data_ok;
    word_t      rdata;
    logic       mem_req;
    logic       mem_we;
    addr_t      mem_addr;
    mem_size_e  mem_size;
    line_t      mem_wdata;
    logic [15:0] mem_wstrb;
    logic       mem_rdy;
    logic       mem_rvalid;
    logic       mem_bvalid;
    line_t      mem_rdata;

    word_t      ref_mem [addr_t];
    logic       res_valid [NSET];
    addr_t      res_line [NSET];
    int         errors;
    int         loads;
    int         hit_checks;
    int         n_rd;
    int         n_wr;
    logic       cur_unc;
    addr_t      cur_addr;
    logic [3:0] cur_wstrb;
    word_t      cur_wdata;

    tb_clk_gen clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    dcache dut_i (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid),
        .req_addr_i     (req_addr),
        .req_size_i     (req_size),
        .req_wstrb_i    (req_wstrb),
        .req_wdata_i    (req_wdata),
        .req_uncached_i (req_uncached),
        .ready_o        (ready),
        .data_ok_o      (data_ok),
        .rdata_o        (rdata),
        .mem_req_o      (mem_req),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_size_o     (mem_size),
        .mem_wdata_o    (mem_wdata),
        .mem_wstrb_o    (mem_wstrb),
        .mem_rdy_i      (mem_rdy),
        .mem_rvalid_i   (mem_rvalid),
        .mem_bvalid_i   (mem_bvalid),
        .mem_rdata_i    (mem_rdata)
    );

    tb_mem_model mem_i (
        .clk          (clk),
        .rst          (rst),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_wstrb_i  (mem_wstrb),
        .mem_rdy_o    (mem_rdy),
        .mem_rvalid_o (mem_rvalid),
        .mem_bvalid_o (mem_bvalid),
        .mem_rdata_o  (mem_rdata)
    );

    // memory contents before any store
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic word_t ref_word(input addr_t a);
        word_t w;
        if (ref_mem.exists(a)) begin
            w = ref_mem[a];
        end else begin
            w = fill_word(a);
        end
        return w;
    endfunction

    function automatic line_t ref_line(input addr_t a);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w * WORD_W +: WORD_W] = ref_word(a + addr_t'(w * 4));
        end
        return l;
    endfunction

    task automatic store_ref(input addr_t a, input logic [3:0] strb, input word_t wd);
        addr_t wa;
        word_t w;
        wa = {a[ADDR_W-1:2], 2'b00};
        w = ref_word(wa);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b * 8 +: 8] = wd[b * 8 +: 8];
            end
        end
        ref_mem[wa] = w;
    endtask

    // checks every memory request against the request in flight
    task automatic watch_mem();
        addr_t       la;
        int          idx;
        int          lane;
        logic [15:0] exp_strb;
        la = {mem_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        idx = int'(mem_addr[OFFSET_W +: INDEX_W]);
        lane = int'(cur_addr[3:2]);
        // byte b of the line belongs to word b / 4
        exp_strb = '0;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (b / 4 == lane) begin
                exp_strb[b] = cur_wstrb[b % 4];
            end
        end
        if (mem_req && !mem_rdy) begin
            $display("mem_req_o raised while mem_rdy_i is low at %0t", $time);
            errors++;
        end
        if (mem_req && mem_we) begin
            n_wr++;
        end
        if (mem_req && !mem_we) begin
            n_rd++;
        end
        if (mem_req && !cur_unc) begin
            if (mem_addr != la || mem_size != SIZE_LINE) begin
                $display("[ERROR] mem_addr_o %h mem_size_o %h, expected %h size %h",
                         mem_addr, mem_size, la, SIZE_LINE);
                errors++;
            end
        end
        if (mem_req && !cur_unc && mem_we) begin
            if (mem_wstrb != 16'hffff) begin
                $display("[ERROR] mem_wstrb_o %h on write-back, expected ffff", mem_wstrb);
                errors++;
            end
            if (mem_wdata != ref_line(la)) begin
                $display("[ERROR] mem_wdata_o %h on write-back to %h, expected %h",
                         mem_wdata, la, ref_line(la));
                errors++;
            end
        end
        // a refill into this set may have pushed out the recorded line
        if (mem_req && !cur_unc && !mem_we) begin
            if (res_valid[idx] && res_line[idx] != la) begin
                res_valid[idx] = 1'b0;
            end
        end
        if (mem_req && cur_unc && mem_we) begin
            if (mem_wstrb != exp_strb) begin
                $display("[ERROR] mem_wstrb_o %h for uncached store to %h, expected %h",
                         mem_wstrb, cur_addr, exp_strb);
                errors++;
            end
            if (mem_wdata[lane * WORD_W +: WORD_W] != cur_wdata) begin
                $display("[ERROR] mem_wdata_o lane %0d %h, expected %h",
                         lane, mem_wdata[lane * WORD_W +: WORD_W], cur_wdata);
                errors++;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        watch_mem();
    endtask

    task automatic run_request(
        input logic       unc,
        input mem_size_e  sz,
        input logic [3:0] strb,
        input addr_t      a,
        input word_t      wd
    );
        int    lat;
        int    idx;
        addr_t la;
        logic  expect_hit;
        word_t exp;
        idx = int'(a[OFFSET_W +: INDEX_W]);
        la = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        expect_hit = !unc && strb == 4'b0 && res_valid[idx] && res_line[idx] == la;
        cur_unc = unc;
        cur_addr = a;
        cur_wstrb = strb;
        cur_wdata = wd;
        n_rd = 0;
        n_wr = 0;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_addr = a;
        req_size = sz;
        req_wstrb = strb;
        req_wdata = wd;
        req_uncached = unc;
        step();
        while (!ready) begin
            step();
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 1;
        step();
        while (!data_ok) begin
            lat++;
            step();
        end
        if (strb == 4'b0) begin
            exp = ref_word({a[ADDR_W-1:2], 2'b00});
            loads++;
            if (rdata != exp) begin
                $display("[ERROR] rdata_o %h for load from %h, expected %h", rdata, a, exp);
                errors++;
            end
        end else begin
            store_ref(a, strb, wd);
        end
        if (expect_hit) begin
            hit_checks++;
            if (lat != 1 || n_rd + n_wr != 0) begin
                $display("resident load to %h took %0d cycles and %0d memory requests",
                         a, lat, n_rd + n_wr);
                errors++;
            end
        end
        if (unc && strb != 4'b0 && !mem_bvalid) begin
            $display("data_ok_o for uncached store to %h came without mem_bvalid_i", a);
            errors++;
        end
        if (unc && (n_rd + n_wr != 1 || n_wr != int'(strb != 4'b0))) begin
            $display("uncached access to %h made %0d reads and %0d writes", a, n_rd, n_wr);
            errors++;
        end
        if (!unc && (n_rd > 1 || n_wr > n_rd)) begin
            $display("cached access to %h made %0d reads and %0d writes", a, n_rd, n_wr);
            errors++;
        end
        if (!unc) begin
            res_valid[idx] = 1'b1;
            res_line[idx] = la;
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int unsigned seed_dummy;
        int          op;
        int          boff;
        int          tag;
        int          set;
        int          wsel;
        logic        unc;
        logic [3:0]  strb;
        mem_size_e   sz;
        addr_t       base;
        word_t       wd;
        seed_dummy = $urandom(87);
        req_valid = 1'b0;
        req_addr = '0;
        req_size = SIZE_WORD;
        req_wstrb = 4'b0;
        req_wdata = '0;
        req_uncached = 1'b0;
        errors = 0;
        loads = 0;
        hit_checks = 0;
        n_rd = 0;
        n_wr = 0;
        cur_unc = 1'b0;
        cur_addr = '0;
        cur_wstrb = 4'b0;
        cur_wdata = '0;
        for (int i = 0; i < NSET; i++) begin
            res_valid[i] = 1'b0;
            res_line[i] = '0;
        end
        step();
        while (rst) begin
            step();
        end
        repeat (3) begin
            step();
            if (!ready || data_ok || mem_req) begin
                $display("[ERROR] after reset ready_o %h data_ok_o %h mem_req_o %h",
                         ready, data_ok, mem_req);
                errors++;
            end
        end
        // 4 tags over 4 sets, plus a separate uncached window
        for (int n = 0; n < NUM_REQ; n++) begin
            op = int'($urandom % 8);
            unc = ($urandom % 5) == 0;
            tag = int'($urandom % 4);
            set = int'($urandom % 4);
            wsel = int'($urandom % 4);
            wd = $urandom;
            boff = 0;
            base = unc ? UNC_BASE : addr_t'(tag << (OFFSET_W + INDEX_W));
            case (op)
                4: begin
                    boff = int'($urandom % 4);
                    sz = SIZE_BYTE;
                    strb = 4'b0001 << boff;
                end
                5: begin
                    boff = 2 * int'($urandom % 2);
                    sz = SIZE_HALF;
                    strb = 4'b0011 << boff;
                end
                6, 7: begin
                    sz = SIZE_WORD;
                    strb = 4'b1111;
                end
                default: begin
                    sz = SIZE_WORD;
                    strb = 4'b0000;
                end
            endcase
            base = base | addr_t'(set << OFFSET_W) | addr_t'(wsel << 2) | addr_t'(boff);
            run_request(unc, sz, strb, base, wd);
        end
        $display("requests %0d, loads checked %0d, hit checks %0d, errors %0d",
                 NUM_REQ, loads, hit_checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: src.f
hdl/dcache_pkg.sv
hdl/way_ram_if.sv
hdl/way_ram.sv
hdl/dcache_lookup.sv
hdl/dcache_miss_ctrl.sv
hdl/dcache.sv
sim/tb_clk_gen.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/way_ram_if.sv
  - hdl/way_ram.sv
  - hdl/dcache_lookup.sv
  - hdl/dcache_miss_ctrl.sv
  - hdl/dcache.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_mem_model.sv
      - sim/tb_dcache.sv
